/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// bus widths
`define CORE_ADDR_W 16
`define CORE_DATA_W 32
`define OPCODE_W 8
`define OFFSET_W 8

// apb register map
`define REG_CTRL 16'h0000
`define REG_CMD_BASE 16'h0004
`define REG_DATA_BASE 16'h0008
`define REG_STATUS 16'h000C
`define REG_RETIRED 16'h0010

// opcodes in bits 31:24 of a command word
`define OP_ADD 8'd1
`define OP_SUB 8'd2
`define OP_AND 8'd3
`define OP_OR 8'd4
`define OP_XOR 8'd5
`define OP_MOV 8'd6
`define OP_JNZ 8'd7
`define OP_HALT 8'd8

`endif

/* rtl/core_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package core_pkg;

  // memory word address
  typedef logic [`CORE_ADDR_W-1:0] addr_t;

  // data or command word
  typedef logic [`CORE_DATA_W-1:0] data_t;

  typedef logic [`OPCODE_W-1:0] opcode_t;

  // operand offset into the data area
  typedef logic [`OFFSET_W-1:0] offset_t;

  // sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    LOAD_S1,
    LOAD_S0,
    EXEC,
    STORE,
    HALTED
  } seq_state_t;

endpackage

`default_nettype wire

/* rtl/mem_port_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if;
  import core_pkg::*;

  // request side, one-cycle pulse with its fields
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;

  // completion side, rdata valid with done
  data_t rdata;
  logic  done;

  modport seq (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata,
    input  done
  );

  modport bus (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata,
    output done
  );

endinterface

`default_nettype wire

/* rtl/core_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module core_regs (
  input  logic            clk,
  input  logic            rst,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  core_pkg::addr_t paddr,
  input  core_pkg::data_t pwdata,
  output core_pkg::data_t prdata,
  output logic            pready,
  output logic            pslverr,
  output logic            start,
  output core_pkg::addr_t cmd_base,
  output core_pkg::addr_t data_base,
  input  logic            busy,
  input  logic            halted,
  input  logic            retired
);
  import core_pkg::*;

  logic  access;
  logic  mapped;
  data_t retired_cnt;

  // access phase of an apb transfer
  assign access  = psel && penable;
  assign pready  = 1'b1;
  assign pslverr = access && !mapped;

  // read mux, also tells which offsets exist
  always_comb begin
    prdata = '0;
    mapped = 1'b1;
    case (paddr)
      `REG_CTRL:      prdata = '0;
      `REG_CMD_BASE:  prdata = data_t'(cmd_base);
      `REG_DATA_BASE: prdata = data_t'(data_base);
      `REG_STATUS:    prdata = data_t'({halted, busy});
      `REG_RETIRED:   prdata = retired_cnt;
      default:        mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start       <= 1'b0;
      cmd_base    <= '0;
      data_base   <= '0;
      retired_cnt <= '0;
    end else begin
      // start pulse from ctrl bit 0
      start <= access && pwrite && (paddr == `REG_CTRL) && pwdata[0] && !busy;
      // bases frozen while a program runs
      if (access && pwrite && !busy) begin
        if (paddr == `REG_CMD_BASE)
          cmd_base <= pwdata[`CORE_ADDR_W-1:0];
        if (paddr == `REG_DATA_BASE)
          data_base <= pwdata[`CORE_ADDR_W-1:0];
      end
      if (start)
        retired_cnt <= '0;
      else if (retired)
        retired_cnt <= retired_cnt + data_t'(1);
    end
  end

  // the sequencer only raises busy after a start, so a pulse can't overlap it
  assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $error("start pulse while the sequencer is busy");

endmodule

`default_nettype wire

/* rtl/cmd_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module cmd_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  core_pkg::addr_t   cmd_base,
  input  core_pkg::addr_t   data_base,
  output logic              busy,
  output logic              halted,
  output logic              retired,
  mem_port_if.seq           mem,
  output logic              alu_go,
  output core_pkg::opcode_t alu_op,
  output core_pkg::data_t   alu_a,
  output core_pkg::data_t   alu_b,
  input  core_pkg::data_t   alu_result,
  input  logic              alu_zero
);
  import core_pkg::*;

  seq_state_t state;
  logic       pending;
  logic       open_q;
  addr_t      cmd_ptr;
  data_t      cmd;
  data_t      src1;
  data_t      src0;
  opcode_t    opcode;
  offset_t    dst_off;
  offset_t    src1_off;
  offset_t    src0_off;
  logic       is_jnz;

  // command word fields
  assign opcode   = cmd[31:24];
  assign dst_off  = cmd[23:16];
  assign src1_off = cmd[15:8];
  assign src0_off = cmd[7:0];
  assign is_jnz   = (opcode == `OP_JNZ);

  assign busy   = (state != IDLE) && (state != HALTED);
  assign halted = (state == HALTED);

  // dst = src1 op src0; jnz tests src1 by or-ing it with zero
  assign alu_op = is_jnz ? opcode_t'(`OP_OR) : opcode;
  assign alu_a  = src1;
  assign alu_b  = is_jnz ? '0 : src0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      pending <= 1'b0;
      cmd_ptr <= '0;
      mem.req <= 1'b0;
      alu_go  <= 1'b0;
      retired <= 1'b0;
    end else begin
      mem.req <= 1'b0;
      alu_go  <= 1'b0;
      retired <= 1'b0;
      case (state)
        IDLE, HALTED: begin
          if (start) begin
            cmd_ptr <= '0;
            state   <= FETCH;
          end
        end
        FETCH: begin
          if (!pending) begin
            mem.req  <= 1'b1;
            mem.we   <= 1'b0;
            mem.addr <= cmd_base + cmd_ptr;
            pending  <= 1'b1;
          end else if (mem.done) begin
            pending <= 1'b0;
            cmd     <= mem.rdata;
            // halt retires right here
            if (mem.rdata[31:24] == `OP_HALT) begin
              retired <= 1'b1;
              state   <= HALTED;
            end else begin
              state <= LOAD_S1;
            end
          end
        end
        LOAD_S1: begin
          if (!pending) begin
            mem.req  <= 1'b1;
            mem.we   <= 1'b0;
            mem.addr <= data_base + addr_t'(src1_off);
            pending  <= 1'b1;
          end else if (mem.done) begin
            pending <= 1'b0;
            src1    <= mem.rdata;
            if (is_jnz)
              state <= EXEC;
            else if (opcode == `OP_MOV)
              state <= STORE;
            else
              state <= LOAD_S0;
          end
        end
        LOAD_S0: begin
          if (!pending) begin
            mem.req  <= 1'b1;
            mem.we   <= 1'b0;
            mem.addr <= data_base + addr_t'(src0_off);
            pending  <= 1'b1;
          end else if (mem.done) begin
            pending <= 1'b0;
            src0    <= mem.rdata;
            state   <= EXEC;
          end
        end
        EXEC: begin
          // go, then one cycle until the alu registers
          if (!pending) begin
            alu_go  <= 1'b1;
            pending <= 1'b1;
          end else if (!alu_go) begin
            pending <= 1'b0;
            if (is_jnz) begin
              retired <= 1'b1;
              cmd_ptr <= alu_zero ? cmd_ptr + addr_t'(1) : addr_t'(dst_off);
              state   <= FETCH;
            end else begin
              state <= STORE;
            end
          end
        end
        STORE: begin
          if (!pending) begin
            mem.req   <= 1'b1;
            mem.we    <= 1'b1;
            mem.addr  <= data_base + addr_t'(dst_off);
            mem.wdata <= (opcode == `OP_MOV) ? src1 : alu_result;
            pending   <= 1'b1;
          end else if (mem.done) begin
            pending <= 1'b0;
            retired <= 1'b1;
            cmd_ptr <= cmd_ptr + addr_t'(1);
            state   <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // open access as seen on the port, independent of the fsm
  always_ff @(posedge clk) begin
    if (rst)
      open_q <= 1'b0;
    else if (mem.req)
      open_q <= 1'b1;
    else if (mem.done)
      open_q <= 1'b0;
  end

  assert property (@(posedge clk) disable iff (rst) mem.req |-> !open_q)
    else $error("memory request raised while an access is outstanding");

endmodule

`default_nettype wire

/* rtl/bus_master.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_master (
  input  logic            clk,
  input  logic            rst,
  mem_port_if.bus         mem,
  output core_pkg::addr_t addr_out,
  output core_pkg::data_t data_out,
  output logic            read_q,
  output logic            write_q,
  input  core_pkg::data_t data_in,
  input  logic            read_dn,
  input  logic            write_dn
);

  logic held;
  logic finish;
  logic accept;

  // one access in flight at a time
  assign held   = read_q || write_q;
  assign finish = (read_q && read_dn) || (write_q && write_dn);
  assign accept = mem.req && !held;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_q   <= 1'b0;
      write_q  <= 1'b0;
      mem.done <= 1'b0;
    end else begin
      mem.done <= 1'b0;
      if (finish) begin
        read_q   <= 1'b0;
        write_q  <= 1'b0;
        mem.done <= 1'b1;
      end else if (accept) begin
        read_q  <= !mem.we;
        write_q <= mem.we;
      end
    end
  end

  // fields stay put while the request is held
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_out <= mem.addr;
      data_out <= mem.wdata;
    end
    // read data captured with read_dn, handed back with done
    if (read_q && read_dn)
      mem.rdata <= data_in;
  end

  assert property (@(posedge clk) disable iff (rst) !(read_q && write_q))
    else $error("read_q and write_q high together");

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module alu (
  input  logic              clk,
  input  logic              rst,
  input  logic              go,
  input  core_pkg::opcode_t op,
  input  core_pkg::data_t   a,
  input  core_pkg::data_t   b,
  output core_pkg::data_t   result,
  output logic              zero
);
  import core_pkg::*;

  data_t next_result;

  // all arithmetic wraps at the word width
  always_comb begin
    case (op)
      `OP_ADD: next_result = a + b;
      `OP_SUB: next_result = a - b;
      `OP_AND: next_result = a & b;
      `OP_OR:  next_result = a | b;
      `OP_XOR: next_result = a ^ b;
      default: next_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (go)
      result <= next_result;
  end

  // zero flag follows the registered result
  always_ff @(posedge clk) begin
    if (rst)
      zero <= 1'b0;
    else if (go)
      zero <= (next_result == '0);
  end

endmodule

`default_nettype wire

/* rtl/core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module core_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  core_pkg::addr_t paddr,
  input  core_pkg::data_t pwdata,
  output core_pkg::data_t prdata,
  output logic            pready,
  output logic            pslverr,
  output core_pkg::addr_t addr_out,
  output core_pkg::data_t data_out,
  input  core_pkg::data_t data_in,
  output logic            read_q,
  output logic            write_q,
  input  logic            read_dn,
  input  logic            write_dn
);
  import core_pkg::*;

  logic    start;
  addr_t   cmd_base;
  addr_t   data_base;
  logic    busy;
  logic    halted;
  logic    retired;
  logic    alu_go;
  opcode_t alu_op;
  data_t   alu_a;
  data_t   alu_b;
  data_t   alu_result;
  logic    alu_zero;

  // sequencer to bus master
  mem_port_if mem_if ();

  core_regs regs0 (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr),
    .start(start), .cmd_base(cmd_base), .data_base(data_base),
    .busy(busy), .halted(halted), .retired(retired)
  );

  cmd_sequencer seq0 (
    .clk(clk), .rst(rst),
    .start(start), .cmd_base(cmd_base), .data_base(data_base),
    .busy(busy), .halted(halted), .retired(retired),
    .mem(mem_if.seq),
    .alu_go(alu_go), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
    .alu_result(alu_result), .alu_zero(alu_zero)
  );

  bus_master bm0 (
    .clk(clk), .rst(rst),
    .mem(mem_if.bus),
    .addr_out(addr_out), .data_out(data_out),
    .read_q(read_q), .write_q(write_q),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn)
  );

  alu alu0 (
    .clk(clk), .rst(rst),
    .go(alu_go), .op(alu_op), .a(alu_a), .b(alu_b),
    .result(alu_result), .zero(alu_zero)
  );

endmodule

`default_nettype wire

/* bench/tb_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module tb_core;
  import core_pkg::*;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  addr_t       paddr;
  data_t       pwdata;
  data_t       prdata;
  logic        pready;
  logic        pslverr;
  addr_t       addr_out;
  data_t       data_out;
  data_t       data_in = '0;
  logic        read_q;
  logic        write_q;
  logic        read_dn = 1'b0;
  logic        write_dn = 1'b0;

  data_t       mem [0:255];
  data_t       ref_mem [0:255];
  data_t       prog [0:31];
  data_t       dat [0:31];
  int          prog_len;
  addr_t       run_cb;
  addr_t       run_db;
  logic [31:0] prog_seed;
  logic [31:0] resp_seed = 32'hb272_d418;
  int          resp_wait;
  logic        resp_active;
  logic        prev_held;
  logic        prev_finish;
  addr_t       prev_addr;
  data_t       prev_data;

  core_top dut0 (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr),
    .addr_out(addr_out), .data_out(data_out), .data_in(data_in),
    .read_q(read_q), .write_q(write_q), .read_dn(read_dn), .write_dn(write_dn)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t rand_word();
    prog_seed = lcg_next(prog_seed);
    return prog_seed;
  endfunction

  function automatic int prog_rand(input int n);
    data_t w;
    w = rand_word();
    return int'(w[31:8]) % n;
  endfunction

  function automatic data_t cmd_word(input int op, input int dst, input int s1, input int s0);
    return {op[7:0], dst[7:0], s1[7:0], s0[7:0]};
  endfunction

  // the memory holds 256 words, upper address bits fold away
  function automatic logic [7:0] word_index(input addr_t a);
    return a[7:0];
  endfunction

  // full 16-bit address must hit the program words or the 32 data words
  function automatic logic in_program_area(input addr_t a);
    return ((a - run_cb) < addr_t'(prog_len)) || ((a - run_db) < addr_t'(32));
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check(input string name, input data_t actual, input data_t expected);
    if (actual !== expected)
      report_failure($sformatf("CHECK FAILED at %0d ns: %s is 0x%h, expected 0x%h",
                               $time, name, actual, expected));
  endtask

  // one apb transfer, setup then access
  task automatic apb_xfer(input logic wr, input addr_t a, input data_t d,
                          output data_t rd, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    check("pready", data_t'(pready), 32'd1);
    rd      = prdata;
    err     = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // memory responder, one request at a time after 0 to 4 cycles
  always @(posedge clk) begin
    if (rst) begin
      read_dn     <= 1'b0;
      write_dn    <= 1'b0;
      resp_active = 1'b0;
      resp_wait   = 0;
    end else begin
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      if ((read_q || write_q) && !read_dn && !write_dn) begin
        if (!resp_active) begin
          if (!in_program_area(addr_out))
            report_failure($sformatf("access to address 0x%h at %0d ns is outside %s",
                                     addr_out, $time, "the command and data areas"));
          resp_seed   = lcg_next(resp_seed);
          resp_wait   = int'(resp_seed[31:8]) % 5;
          resp_active = 1'b1;
        end
        if (resp_wait == 0) begin
          resp_active = 1'b0;
          if (read_q) begin
            data_in <= mem[word_index(addr_out)];
            read_dn <= 1'b1;
          end else begin
            mem[word_index(addr_out)] = data_out;
            write_dn <= 1'b1;
          end
        end else begin
          resp_wait = resp_wait - 1;
        end
      end
    end
  end

  // memory port protocol watcher
  always @(posedge clk) begin
    if (rst) begin
      prev_held   <= 1'b0;
      prev_finish <= 1'b0;
    end else begin
      check("read_q and write_q together", data_t'(read_q && write_q), '0);
      if (prev_held && (read_q || write_q)) begin
        check("addr_out during request", data_t'(addr_out), data_t'(prev_addr));
        check("data_out during request", data_out, prev_data);
      end
      if (prev_finish)
        check("request held after done", data_t'(read_q || write_q), '0);
      prev_held   <= read_q || write_q;
      prev_finish <= (read_q && read_dn) || (write_q && write_dn);
      prev_addr   <= addr_out;
      prev_data   <= data_out;
    end
  end

  task automatic place_program(input addr_t cb, input addr_t db);
    for (int i = 0; i < 256; i++)
      mem[i] = rand_word() ^ data_t'(i);
    for (int i = 0; i < prog_len; i++)
      mem[word_index(cb + addr_t'(i))] = prog[i];
    for (int i = 0; i < 32; i++)
      mem[word_index(db + addr_t'(i))] = dat[i];
  endtask

  // 10 to 30 alu and mov commands, then halt
  task automatic build_straight();
    int n;
    n = 10 + prog_rand(21);
    for (int i = 0; i < n; i++)
      prog[i] = cmd_word(1 + prog_rand(6), prog_rand(32), prog_rand(32), prog_rand(32));
    prog[n]  = cmd_word(`OP_HALT, 0, 0, 0);
    prog_len = n + 1;
    for (int i = 0; i < 32; i++)
      dat[i] = rand_word();
  endtask

  // counter in word 0, decrement in word 1, sum of word 3 into word 2
  task automatic build_loop();
    for (int i = 0; i < 32; i++)
      dat[i] = rand_word();
    dat[0]   = data_t'(3 + prog_rand(5));
    dat[1]   = 32'd1;
    prog[0]  = cmd_word(`OP_ADD, 2, 2, 3);
    prog[1]  = cmd_word(`OP_SUB, 0, 0, 1);
    prog[2]  = cmd_word(`OP_JNZ, 0, 0, 0);
    prog[3]  = cmd_word(`OP_HALT, 0, 0, 0);
    prog_len = 4;
  endtask

  // reference model: dst = src1 op src0, jnz jumps on a nonzero src1
  task automatic run_model(input addr_t cb, input addr_t db, output int count);
    addr_t      ptr;
    data_t      w;
    data_t      s1;
    data_t      s0;
    data_t      r;
    logic [7:0] op;
    logic       halt_seen;
    ptr       = '0;
    count     = 0;
    halt_seen = 1'b0;
    while (!halt_seen && count < 2000) begin
      w  = ref_mem[word_index(cb + ptr)];
      op = w[31:24];
      s1 = ref_mem[word_index(db + addr_t'(w[15:8]))];
      s0 = ref_mem[word_index(db + addr_t'(w[7:0]))];
      count++;
      ptr = ptr + addr_t'(1);
      case (op)
        `OP_ADD: r = s1 + s0;
        `OP_SUB: r = s1 - s0;
        `OP_AND: r = s1 & s0;
        `OP_OR:  r = s1 | s0;
        `OP_XOR: r = s1 ^ s0;
        `OP_MOV: r = s1;
        default: r = '0;
      endcase
      if (op == `OP_HALT) begin
        halt_seen = 1'b1;
      end else if (op == `OP_JNZ) begin
        if (s1 != '0)
          ptr = addr_t'(w[23:16]);
      end else begin
        ref_mem[word_index(db + addr_t'(w[23:16]))] = r;
      end
    end
    if (!halt_seen)
      report_failure("the reference model did not reach a HALT command");
  endtask

  task automatic wait_halted();
    data_t st;
    logic  err;
    int    polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < 3000) begin
      apb_xfer(1'b0, `REG_STATUS, '0, st, err);
      polls++;
    end
    if (!st[1])
      report_failure("timeout: the halted bit in STATUS never came up");
  endtask

  task automatic run_and_compare(input addr_t cb, input addr_t db, input logic poke);
    int    expected_count;
    data_t rd;
    logic  err;
    run_cb = cb;
    run_db = db;
    apb_xfer(1'b1, `REG_CMD_BASE, data_t'(cb), rd, err);
    apb_xfer(1'b1, `REG_DATA_BASE, data_t'(db), rd, err);
    ref_mem = mem;
    run_model(cb, db, expected_count);
    apb_xfer(1'b1, `REG_CTRL, 32'd1, rd, err);
    if (poke) begin
      apb_xfer(1'b1, `REG_CMD_BASE, data_t'(~cb), rd, err);
      apb_xfer(1'b1, `REG_DATA_BASE, data_t'(~db), rd, err);
    end
    wait_halted();
    apb_xfer(1'b0, `REG_CMD_BASE, '0, rd, err);
    check("cmd_base", rd, data_t'(cb));
    apb_xfer(1'b0, `REG_DATA_BASE, '0, rd, err);
    check("data_base", rd, data_t'(db));
    apb_xfer(1'b0, `REG_STATUS, '0, rd, err);
    check("status", rd, 32'h2);
    apb_xfer(1'b0, `REG_RETIRED, '0, rd, err);
    check("retired", rd, data_t'(expected_count));
    for (int i = 0; i < 256; i++)
      check($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
  endtask

  task automatic test_registers();
    data_t rd;
    logic  err;
    apb_xfer(1'b0, `REG_STATUS, '0, rd, err);
    check("status", rd, '0);
    check("pslverr", data_t'(err), '0);
    apb_xfer(1'b0, `REG_RETIRED, '0, rd, err);
    check("retired", rd, '0);
    apb_xfer(1'b1, `REG_CMD_BASE, 32'h0000_1234, rd, err);
    apb_xfer(1'b1, `REG_DATA_BASE, 32'h0000_a5c3, rd, err);
    apb_xfer(1'b0, `REG_CMD_BASE, '0, rd, err);
    check("cmd_base", rd, 32'h0000_1234);
    apb_xfer(1'b0, `REG_DATA_BASE, '0, rd, err);
    check("data_base", rd, 32'h0000_a5c3);
    // unmapped offsets
    apb_xfer(1'b0, 16'h0020, '0, rd, err);
    check("pslverr on read", data_t'(err), 32'd1);
    apb_xfer(1'b1, 16'h0014, 32'hffff_ffff, rd, err);
    check("pslverr on write", data_t'(err), 32'd1);
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    run_cb      = '0;
    run_db      = '0;
    prog_len    = 0;
    prog_seed   = 32'hb272_d418;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_registers();
    for (int r = 0; r < 4; r++) begin
      build_straight();
      place_program(16'h0000, 16'h0080);
      run_and_compare(16'h0000, 16'h0080, 1'b0);
    end
    build_loop();
    place_program(16'h0000, 16'h0080);
    run_and_compare(16'h0000, 16'h0080, 1'b0);
    // one program at two base pairs, bases poked while busy
    build_straight();
    place_program(16'h0000, 16'h0080);
    run_and_compare(16'h0000, 16'h0080, 1'b1);
    place_program(16'h0140, 16'h02e0);
    run_and_compare(16'h0140, 16'h02e0, 1'b1);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
rtl/core_pkg.sv
rtl/mem_port_if.sv
rtl/core_regs.sv
rtl/cmd_sequencer.sv
rtl/bus_master.sv
rtl/alu.sv
rtl/core_top.sv
bench/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_core
./obj_dir/Vtb_core > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
  exit 1
fi
grep -q "Simulation completed successfully" sim.log
echo "run passed"
